/* vic_pkg.sv */
package vic_pkg;

  // ====================================================================
  // Widths that carry a meaning
  // ====================================================================

  // Bus cycle index within one raster line
  typedef logic [5:0]  raster_x_t;
  // Raster line number within one frame
  typedef logic [8:0]  raster_y_t;
  // Clock phase within one bus cycle
  typedef logic [2:0]  phase_t;
  typedef logic [5:0]  reg_addr_t;
  typedef logic [7:0]  cpu_data_t;
  typedef logic [13:0] vram_addr_t;
  // Colour nibble in bits 11:8, screen code in bits 7:0
  typedef logic [11:0] vdata_t;
  typedef logic [3:0]  color_t;

  // ====================================================================
  // Frame geometry
  // ====================================================================

  localparam int CLKS_PER_CYCLE  = 8;
  localparam int CYCLES_PER_LINE = 63;
  localparam int LINES_PER_FRAME = 312;
  // Screen codes fetched on every bad line
  localparam int MATRIX_COLS     = 40;

  localparam raster_y_t FIRST_DMA_LINE = 9'd48;
  localparam raster_y_t LAST_DMA_LINE  = 9'd247;

  // BA drops three cycles ahead of the first stolen cycle
  localparam raster_x_t BA_CYCLE    = 6'd12;
  localparam raster_x_t FETCH_FIRST = 6'd15;
  localparam raster_x_t FETCH_LAST  = 6'd54;

  localparam raster_x_t WIN_X_FIRST = 6'd16;
  localparam raster_x_t WIN_X_LAST  = 6'd55;
  localparam raster_y_t WIN_Y_FIRST = 9'd51;
  localparam raster_y_t WIN_Y_LAST  = 9'd250;

  localparam raster_x_t HSYNC_CYCLE_FIRST = 6'd0;
  localparam raster_x_t HSYNC_CYCLE_LAST  = 6'd4;
  localparam raster_y_t VSYNC_LINE_FIRST  = 9'd0;
  localparam raster_y_t VSYNC_LINE_LAST   = 9'd2;

  // ====================================================================
  // Register map
  // ====================================================================

  localparam reg_addr_t REG_CTRL1  = 6'h11;
  localparam reg_addr_t REG_RASTER = 6'h12;
  localparam reg_addr_t REG_MEMPTR = 6'h18;
  localparam reg_addr_t REG_IRQ    = 6'h19;
  localparam reg_addr_t REG_IRQ_EN = 6'h1A;
  localparam reg_addr_t REG_BORDER = 6'h20;
  localparam reg_addr_t REG_BG0    = 6'h21;

  // Bad-line DMA sequencer
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    BA_WAIT = 2'd1,
    FETCH   = 2'd2,
    DONE    = 2'd3
  } dma_state_t;

endpackage

/* vic_raster_if.sv */
`timescale 1ns/1ps

interface vic_raster_if;
  import vic_pkg::*;

  // Timing from the raster timer
  phase_t    phase;
  logic      phi02;
  logic      cycle_end;
  raster_x_t raster_x;
  raster_y_t raster_y;

  // Decoded register fields
  logic       den;
  logic [2:0] yscroll;
  // Video matrix base in 1 KB units
  logic [3:0] vm_base;
  // Character base in 2 KB units
  logic [2:0] cb_base;
  color_t     border_color;
  color_t     bg_color;

  // Set for the whole of a line that steals the bus
  logic bad_line;

  modport timer (output phase, phi02, cycle_end, raster_x, raster_y);

  modport regs (input phase, phi02, cycle_end, raster_x, raster_y,
                output den, yscroll, vm_base, cb_base, border_color, bg_color);

  modport dma (input phase, phi02, cycle_end, raster_x, raster_y,
               input den, yscroll, vm_base, cb_base, border_color, bg_color,
               output bad_line);

  modport pix (input phase, phi02, cycle_end, raster_x, raster_y,
               input den, yscroll, vm_base, cb_base, border_color, bg_color,
               input bad_line);

endinterface

/* vic_raster_timer.sv */
`timescale 1ns/1ps

module vic_raster_timer (
  input  logic               clk,
  input  logic               rst,
  input  vic_pkg::raster_y_t raster_compare,
  output logic               hsync,
  output logic               vsync,
  output logic               raster_hit,
  vic_raster_if.timer        rif
);
  import vic_pkg::*;

  logic      line_end;
  raster_x_t x_next;
  raster_y_t y_next;

  // ====================================================================
  // Bus cycle phasing
  // ====================================================================

  // The CPU owns the bus while phi02 is high, in phases 4 to 7
  assign rif.phi02     = rif.phase >= phase_t'(CLKS_PER_CYCLE / 2);
  assign rif.cycle_end = rif.phase == phase_t'(CLKS_PER_CYCLE - 1);

  // Last clk of the last cycle in the line
  assign line_end = rif.cycle_end && (rif.raster_x == raster_x_t'(CYCLES_PER_LINE - 1));

  // Position that the counters hold in the next clk
  always_comb begin
    x_next = rif.raster_x;
    y_next = rif.raster_y;
    if (line_end) begin
      x_next = '0;
      if (rif.raster_y == raster_y_t'(LINES_PER_FRAME - 1))
        y_next = '0;
      else
        y_next = rif.raster_y + 9'd1;
    end else if (rif.cycle_end) begin
      x_next = rif.raster_x + 6'd1;
    end
  end

  // ====================================================================
  // Counters and syncs
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      rif.phase    <= '0;
      rif.raster_x <= '0;
      rif.raster_y <= '0;
      hsync        <= 1'b0;
      vsync        <= 1'b0;
    end else begin
      rif.phase    <= rif.phase + 3'd1;
      rif.raster_x <= x_next;
      rif.raster_y <= y_next;
      // Syncs come from the next position so they line up with the counters
      hsync <= x_next inside {[HSYNC_CYCLE_FIRST:HSYNC_CYCLE_LAST]};
      vsync <= y_next inside {[VSYNC_LINE_FIRST:VSYNC_LINE_LAST]};
    end
  end

  // Pulses on the edge where the line number steps onto the compare value
  assign raster_hit = line_end && (y_next == raster_compare);

  // The cycle counter wraps after cycle 62 and never runs past it
  a_x_in_line: assert property (@(posedge clk) disable iff (rst)
    rif.raster_x <= raster_x_t'(CYCLES_PER_LINE - 1));

endmodule

/* vic_reg_file.sv */
`timescale 1ns/1ps

module vic_reg_file (
  input  logic               clk,
  input  logic               rst,
  input  logic               cs_n,
  input  logic               rw,
  input  vic_pkg::reg_addr_t addr,
  input  vic_pkg::cpu_data_t data_in,
  input  logic               raster_hit,
  output vic_pkg::cpu_data_t data_out,
  output logic               data_oe,
  output logic               irq_n,
  output vic_pkg::raster_y_t raster_compare,
  vic_raster_if.regs         rif
);
  import vic_pkg::*;

  cpu_data_t ctrl1;
  cpu_data_t raster_lo;
  cpu_data_t memptr;
  color_t    border_color;
  color_t    bg_color;
  logic      irq_status;
  logic      irq_en;
  logic      irq_pending;
  logic      irq_clear;
  logic      access;
  logic      wr_strobe;

  // ====================================================================
  // Bus decode
  // ====================================================================

  // An access only counts while phi02 is high
  assign access    = !cs_n && rif.phi02;
  // Writes land on the last phase so the CPU data has settled
  assign wr_strobe = access && !rw && (rif.phase == phase_t'(CLKS_PER_CYCLE - 1));
  assign data_oe   = access && rw;

  assign irq_pending = irq_status && irq_en;
  // Writing 1 to bit 0 of the status register drops the raster flag
  assign irq_clear   = wr_strobe && (addr == REG_IRQ) && data_in[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl1        <= '0;
      raster_lo    <= '0;
      memptr       <= '0;
      border_color <= '0;
      bg_color     <= '0;
      irq_en       <= 1'b0;
      irq_status   <= 1'b0;
      irq_n        <= 1'b1;
    end else begin
      if (wr_strobe) begin
        case (addr)
          REG_CTRL1:  ctrl1        <= data_in;
          REG_RASTER: raster_lo    <= data_in;
          REG_MEMPTR: memptr       <= data_in;
          REG_IRQ_EN: irq_en       <= data_in[0];
          REG_BORDER: border_color <= data_in[3:0];
          REG_BG0:    bg_color     <= data_in[3:0];
          default: ;
        endcase
      end
      // A new hit beats a clear that arrives in the same clk
      if (raster_hit)
        irq_status <= 1'b1;
      else if (irq_clear)
        irq_status <= 1'b0;
      // The line lets go on the same edge that a clear takes effect
      irq_n <= !(irq_pending && (raster_hit || !irq_clear));
    end
  end

  // ====================================================================
  // Read mux
  // ====================================================================

  always_comb begin
    case (addr)
      REG_CTRL1:  data_out = ctrl1;
      // Raster reads see the live line, not the compare value
      REG_RASTER: data_out = rif.raster_y[7:0];
      REG_MEMPTR: data_out = memptr;
      REG_IRQ:    data_out = {irq_pending, 6'b000000, irq_status};
      REG_IRQ_EN: data_out = {7'b0000000, irq_en};
      REG_BORDER: data_out = {4'b0000, border_color};
      REG_BG0:    data_out = {4'b0000, bg_color};
      default:    data_out = 8'hFF;
    endcase
  end

  // Fields used by the DMA and pixel blocks
  assign raster_compare   = {ctrl1[7], raster_lo};
  assign rif.den          = ctrl1[4];
  assign rif.yscroll      = ctrl1[2:0];
  assign rif.vm_base      = memptr[7:4];
  assign rif.cb_base      = memptr[3:1];
  assign rif.border_color = border_color;
  assign rif.bg_color     = bg_color;

  // The interrupt line is only low while the status bit is set
  a_irq_source: assert property (@(posedge clk) disable iff (rst)
    !irq_n |-> irq_status);

endmodule

/* vic_dma_ctrl.sv */
`timescale 1ns/1ps

module vic_dma_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  vic_pkg::vdata_t     data_bus,
  output logic                ba,
  output logic                aec,
  output vic_pkg::vram_addr_t ram_addr,
  output vic_pkg::vdata_t     fetch_code,
  output vic_pkg::cpu_data_t  char_bits,
  output logic                char_valid,
  vic_raster_if.dma           rif
);
  import vic_pkg::*;

  dma_state_t state;
  logic       den_seen;
  logic [4:0] vm_row;
  logic [2:0] rc;
  vdata_t     line_buf [MATRIX_COLS];
  logic       line_end;
  logic       in_dma_lines;
  logic       in_window;
  logic       g_capture;
  raster_x_t  m_col;
  raster_x_t  g_col;
  vdata_t     g_entry;
  logic [9:0] vm_off;

  // ====================================================================
  // Bad line detection and bus sequencing
  // ====================================================================

  assign line_end     = rif.cycle_end && (rif.raster_x == raster_x_t'(CYCLES_PER_LINE - 1));
  assign in_dma_lines = (rif.raster_y >= FIRST_DMA_LINE) && (rif.raster_y <= LAST_DMA_LINE);

  // DEN only counts if it was seen somewhere in line 48 of this frame
  assign rif.bad_line = in_dma_lines && (rif.raster_y[2:0] == rif.yscroll) &&
                        (den_seen || ((rif.raster_y == FIRST_DMA_LINE) && rif.den));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      den_seen <= 1'b0;
      vm_row   <= '0;
      rc       <= '0;
    end else begin
      if (rif.raster_y == '0) begin
        den_seen <= 1'b0;
        vm_row   <= '0;
      end else if ((rif.raster_y == FIRST_DMA_LINE) && rif.den) begin
        den_seen <= 1'b1;
      end
      // Row counter steps every line and restarts on each bad line
      if (line_end)
        rc <= rc + 3'd1;
      if (rif.cycle_end) begin
        case (state)
          IDLE:
            if ((rif.raster_x == raster_x_t'(BA_CYCLE - 1)) && rif.bad_line)
              state <= BA_WAIT;
          BA_WAIT:
            if (rif.raster_x == raster_x_t'(FETCH_FIRST - 1)) begin
              state <= FETCH;
              rc    <= '0;
            end
          FETCH:
            if (rif.raster_x == FETCH_LAST) begin
              state  <= DONE;
              vm_row <= vm_row + 5'd1;
            end
          // Hold off until the line ends so one line never fetches twice
          DONE:
            if (line_end)
              state <= IDLE;
          default: state <= IDLE;
        endcase
      end
    end
  end

  assign ba  = !((state == BA_WAIT) || (state == FETCH));
  // The bus is only taken in the CPU half of each fetch cycle
  assign aec = !((state == FETCH) && rif.phi02);

  // ====================================================================
  // Address generation and capture
  // ====================================================================

  assign m_col  = rif.raster_x - FETCH_FIRST;
  assign vm_off = 10'(vm_row * MATRIX_COLS) + 10'(m_col);

  assign in_window = rif.den &&
                     (rif.raster_x >= WIN_X_FIRST) && (rif.raster_x <= WIN_X_LAST) &&
                     (rif.raster_y >= WIN_Y_FIRST) && (rif.raster_y <= WIN_Y_LAST);

  // Character fetch in window cycle c reads the code stored for column c-16
  assign g_col   = rif.raster_x - WIN_X_FIRST;
  assign g_entry = (g_col < raster_x_t'(MATRIX_COLS)) ? line_buf[g_col] : '0;

  assign ram_addr = rif.phi02 ? {rif.vm_base, vm_off} : {rif.cb_base, g_entry[7:0], rc};

  assign g_capture = in_window && (rif.phase == phase_t'(CLKS_PER_CYCLE / 2 - 1));

  // Screen codes land at the end of each stolen cycle
  always_ff @(posedge clk) begin
    if ((state == FETCH) && rif.cycle_end)
      line_buf[m_col] <= data_bus;
  end

  always_ff @(posedge clk) begin
    if (g_capture) begin
      char_bits  <= data_bus[7:0];
      fetch_code <= g_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      char_valid <= 1'b0;
    else
      char_valid <= g_capture;
  end

  // The CPU gets at least three cycles of warning before AEC is pulled
  a_ba_lead: assert property (@(posedge clk) disable iff (rst)
    !aec |-> !ba && $past(!ba, 3 * CLKS_PER_CYCLE));

endmodule

/* vic_pixel_gen.sv */
`timescale 1ns/1ps

module vic_pixel_gen (
  input  logic               clk,
  input  logic               rst,
  input  vic_pkg::vdata_t    fetch_code,
  input  vic_pkg::cpu_data_t char_bits,
  input  logic               char_valid,
  output vic_pkg::color_t    pixel_color,
  output logic               display_active,
  vic_raster_if.pix          rif
);
  import vic_pkg::*;

  cpu_data_t pend_bits;
  color_t    pend_color;
  logic      pend_valid;
  cpu_data_t shifter;
  color_t    fg_color;
  logic      in_window;
  logic      win_q;

  assign in_window = rif.den &&
                     (rif.raster_x >= WIN_X_FIRST) && (rif.raster_x <= WIN_X_LAST) &&
                     (rif.raster_y >= WIN_Y_FIRST) && (rif.raster_y <= WIN_Y_LAST);

  // ====================================================================
  // Staging of the fetched character
  // ====================================================================

  // The char row arrives mid-cycle and waits here for the next phase 0
  always_ff @(posedge clk) begin
    if (rst)
      pend_valid <= 1'b0;
    else if (rif.cycle_end)
      pend_valid <= 1'b0;
    else if (char_valid)
      pend_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (char_valid) begin
      pend_bits  <= char_bits;
      pend_color <= fetch_code[11:8];
    end
  end

  // ====================================================================
  // Shifter and border
  // ====================================================================

  // Window flag trails the fetch by one bus cycle like the pixel data
  always_ff @(posedge clk) begin
    if (rst)
      win_q <= 1'b0;
    else if (rif.cycle_end)
      win_q <= in_window && pend_valid;
  end

  // Loaded so the first pixel shows in phase 0, then MSB first
  always_ff @(posedge clk) begin
    if (rif.cycle_end) begin
      shifter  <= pend_bits;
      fg_color <= pend_color;
    end else begin
      shifter <= {shifter[6:0], 1'b0};
    end
  end

  assign display_active = win_q;
  assign pixel_color    = !win_q     ? rif.border_color :
                          shifter[7] ? fg_color : rif.bg_color;

endmodule

/* vic_top.sv */
`timescale 1ns/1ps

module vic_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                cs_n,
  input  logic                rw,
  input  vic_pkg::reg_addr_t  addr,
  input  vic_pkg::cpu_data_t  data_in,
  input  vic_pkg::vdata_t     data_bus,
  output logic                phi02,
  output logic                ba,
  output logic                aec,
  output logic                irq_n,
  output vic_pkg::cpu_data_t  data_out,
  output logic                data_oe,
  output vic_pkg::vram_addr_t ram_addr,
  output logic                hsync,
  output logic                vsync,
  output vic_pkg::color_t     pixel_color
);
  import vic_pkg::*;

  raster_y_t raster_compare;
  logic      raster_hit;
  vdata_t    fetch_code;
  cpu_data_t char_bits;
  logic      char_valid;

  // Shared timing and register fields
  vic_raster_if rif ();

  assign phi02 = rif.phi02;

  vic_raster_timer u_timer (
    .clk            (clk),
    .rst            (rst),
    .raster_compare (raster_compare),
    .hsync          (hsync),
    .vsync          (vsync),
    .raster_hit     (raster_hit),
    .rif            (rif.timer)
  );

  vic_reg_file u_regs (
    .clk            (clk),
    .rst            (rst),
    .cs_n           (cs_n),
    .rw             (rw),
    .addr           (addr),
    .data_in        (data_in),
    .raster_hit     (raster_hit),
    .data_out       (data_out),
    .data_oe        (data_oe),
    .irq_n          (irq_n),
    .raster_compare (raster_compare),
    .rif            (rif.regs)
  );

  vic_dma_ctrl u_dma (
    .clk        (clk),
    .rst        (rst),
    .data_bus   (data_bus),
    .ba         (ba),
    .aec        (aec),
    .ram_addr   (ram_addr),
    .fetch_code (fetch_code),
    .char_bits  (char_bits),
    .char_valid (char_valid),
    .rif        (rif.dma)
  );

  vic_pixel_gen u_pix (
    .clk            (clk),
    .rst            (rst),
    .fetch_code     (fetch_code),
    .char_bits      (char_bits),
    .char_valid     (char_valid),
    .pixel_color    (pixel_color),
    .display_active (),
    .rif            (rif.pix)
  );

endmodule

/* vic_top_tb.sv */
`timescale 1ns/1ps

module vic_top_tb;
  import vic_pkg::*;

  localparam int FRAME_CLKS   = CLKS_PER_CYCLE * CYCLES_PER_LINE * LINES_PER_FRAME;
  // Two frames of traffic plus a tenth of margin
  localparam int TIMEOUT_CLKS = FRAME_CLKS * 2 + FRAME_CLKS * 2 / 10;
  localparam int N_REGS       = 10;

  logic       clk;
  logic       rst;
  logic       cs_n;
  logic       rw;
  reg_addr_t  addr;
  cpu_data_t  data_in;
  vdata_t     data_bus;
  logic       phi02;
  logic       ba;
  logic       aec;
  logic       irq_n;
  cpu_data_t  data_out;
  logic       data_oe;
  vram_addr_t ram_addr;
  logic       hsync;
  logic       vsync;
  color_t     pixel_color;

  // Register writes with the readback each one should give
  reg_addr_t tbl_addr [N_REGS] = '{REG_BORDER, REG_BG0, REG_MEMPTR, REG_IRQ_EN, REG_IRQ_EN,
                                   REG_IRQ_EN, 6'h3F, 6'h00, REG_CTRL1, REG_IRQ};
  cpu_data_t tbl_wr   [N_REGS] = '{8'hF6, 8'hA1, 8'h5A, 8'hFE, 8'h01,
                                   8'h00, 8'h55, 8'h12, 8'h03, 8'h01};
  cpu_data_t tbl_exp  [N_REGS] = '{8'h06, 8'h01, 8'h5A, 8'h00, 8'h01,
                                   8'h00, 8'hFF, 8'hFF, 8'h03, 8'h00};
  string     tbl_name [N_REGS] = '{"border nibble", "background nibble", "memptr",
                                   "irq enable mask", "irq enable set", "irq enable clear",
                                   "unmapped 0x3F", "unmapped 0x00", "ctrl1", "irq status idle"};

  int err_data = 0;
  int err_addr = 0;
  int err_color = 0;
  int err_bit = 0;
  int clk_count = 0;
  int seed;
  int irq_line;
  int last_read_y;
  cpu_data_t rd;

  // Position model and shadow copies of what the CPU has written
  int t_phase;
  int t_x;
  int t_y;
  int t_frame;
  cpu_data_t ctrl1_sh = '0;
  cpu_data_t memptr_sh = '0;
  color_t border_sh = '0;
  color_t bg_sh = '0;
  logic mon_on = 1'b0;
  logic video_on = 1'b0;
  logic den_seen_m = 1'b0;
  logic bad_m;
  logic win_m;
  logic ba_prev = 1'b1;
  logic aec_prev = 1'b1;
  int row_m;
  int rc_m;
  int aec_cnt = 0;
  int ba_fall = 0;
  int bad_seen = 0;

  vic_top u_vic_top (
    .clk(clk), .rst(rst), .cs_n(cs_n), .rw(rw), .addr(addr), .data_in(data_in),
    .data_bus(data_bus), .phi02(phi02), .ba(ba), .aec(aec), .irq_n(irq_n),
    .data_out(data_out), .data_oe(data_oe), .ram_addr(ram_addr), .hsync(hsync),
    .vsync(vsync), .pixel_color(pixel_color)
  );

  // Video memory returns the low address nibble as colour and the inverted low byte as code
  assign data_bus = {ram_addr[3:0], ~ram_addr[7:0]};

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================

  task automatic check_data(input string name, input cpu_data_t exp, input cpu_data_t act);
    if (act !== exp) begin
      err_data++;
      $display("FAIL %s expected %h actual %h (line %0d cycle %0d)", name, exp, act, t_y, t_x);
    end
  endtask

  task automatic check_addr(input string name, input vram_addr_t exp, input vram_addr_t act);
    if (act !== exp) begin
      err_addr++;
      $display("FAIL %s expected %h actual %h (line %0d cycle %0d)", name, exp, act, t_y, t_x);
    end
  endtask

  task automatic check_color(input string name, input color_t exp, input color_t act);
    if (act !== exp) begin
      err_color++;
      $display("FAIL %s expected %h actual %h (line %0d cycle %0d phase %0d)",
               name, exp, act, t_y, t_x, t_phase);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_bit++;
      $display("FAIL %s expected %b actual %b (line %0d cycle %0d phase %0d)",
               name, exp, act, t_y, t_x, t_phase);
    end
  endtask

  // ====================================================================
  // Address and pixel rules
  // ====================================================================

  function automatic vram_addr_t matrix_addr(int row, int col);
    return vram_addr_t'(memptr_sh[7:4] * 1024 + row * MATRIX_COLS + col);
  endfunction

  function automatic vram_addr_t char_addr(int row, int col, int rc);
    vram_addr_t va;
    cpu_data_t  code;
    va   = matrix_addr(row, col);
    code = ~va[7:0];
    return vram_addr_t'(memptr_sh[3:1] * 2048 + code * 8 + rc);
  endfunction

  // Pixel p of a column is bit 7-p of the inverted low byte of its char address
  function automatic color_t pixel_expect(int row, int col, int rc, int p);
    vram_addr_t va;
    vram_addr_t ca;
    cpu_data_t  bits;
    va   = matrix_addr(row, col);
    ca   = char_addr(row, col, rc);
    bits = ~ca[7:0];
    if (bits[7 - p])
      return va[3:0];
    return bg_sh;
  endfunction

  // ====================================================================
  // CPU bus
  // ====================================================================

  // Holds the access over one whole phi02 high half so phase 7 commits it
  task automatic bus_write(input reg_addr_t a, input cpu_data_t d);
    @(posedge clk);
    cs_n    <= 1'b0;
    rw      <= 1'b0;
    addr    <= a;
    data_in <= d;
    do @(negedge clk); while (!phi02);
    while (phi02) begin
      check_bit("data_oe during write", 1'b0, data_oe);
      @(negedge clk);
    end
    @(posedge clk);
    cs_n <= 1'b1;
    rw   <= 1'b1;
    case (a)
      REG_CTRL1:  ctrl1_sh  = d;
      REG_MEMPTR: memptr_sh = d;
      REG_BORDER: border_sh = d[3:0];
      REG_BG0:    bg_sh     = d[3:0];
      default: ;
    endcase
  endtask

  // Read data is taken on the last phi02 high sample
  task automatic bus_read(input reg_addr_t a, output cpu_data_t d);
    @(posedge clk);
    cs_n <= 1'b0;
    rw   <= 1'b1;
    addr <= a;
    do begin
      @(negedge clk);
      if (!phi02)
        check_bit("data_oe before read phase", 1'b0, data_oe);
    end while (!phi02);
    while (phi02) begin
      check_bit("data_oe in read phase", 1'b1, data_oe);
      d = data_out;
      last_read_y = t_y;
      @(negedge clk);
    end
    @(posedge clk);
    cs_n <= 1'b1;
  endtask

  task automatic wait_line(input int frame, input int line);
    do @(negedge clk); while (!(t_frame == frame && t_y == line && t_x == 0));
  endtask

  // ====================================================================
  // Raster position model and continuous checks
  // ====================================================================

  always @(posedge clk) begin
    if (rst) begin
      t_phase <= 0;
      t_x     <= 0;
      t_y     <= 0;
      t_frame <= 0;
    end else begin
      t_phase <= (t_phase + 1) % CLKS_PER_CYCLE;
      if (t_phase == CLKS_PER_CYCLE - 1) begin
        if (t_x == CYCLES_PER_LINE - 1) begin
          t_x <= 0;
          if (t_y == LINES_PER_FRAME - 1) begin
            t_y     <= 0;
            t_frame <= t_frame + 1;
          end else begin
            t_y <= t_y + 1;
          end
        end else begin
          t_x <= t_x + 1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (mon_on) begin
      // DEN is latched once per frame, on line 48
      if (t_y == 0)
        den_seen_m = 1'b0;
      else if (t_y == FIRST_DMA_LINE && ctrl1_sh[4])
        den_seen_m = 1'b1;
      bad_m = den_seen_m && t_y >= FIRST_DMA_LINE && t_y <= LAST_DMA_LINE &&
              (t_y % 8) == ctrl1_sh[2:0];
      win_m = ctrl1_sh[4] && t_y >= WIN_Y_FIRST && t_y <= WIN_Y_LAST;
      row_m = (t_y - WIN_Y_FIRST) / 8;
      rc_m  = (t_y - WIN_Y_FIRST) % 8;

      check_bit("phi02", t_phase >= CLKS_PER_CYCLE / 2, phi02);
      check_bit("hsync", t_x <= HSYNC_CYCLE_LAST, hsync);
      check_bit("vsync", t_y <= VSYNC_LINE_LAST, vsync);
      check_bit("ba", !(bad_m && t_x >= BA_CYCLE && t_x <= FETCH_LAST), ba);
      check_bit("aec", !(bad_m && t_x >= FETCH_FIRST && t_x <= FETCH_LAST &&
                         t_phase >= CLKS_PER_CYCLE / 2), aec);
      if (cs_n)
        check_bit("data_oe idle", 1'b0, data_oe);

      // BA leads the first stolen cycle by three cycles and AEC drops mid-cycle
      if (!ba && ba_prev)
        ba_fall = clk_count;
      if (!aec && aec_prev && aec_cnt == 0)
        check_data("ba lead in clk", 8'd28, cpu_data_t'(clk_count - ba_fall));
      if (t_phase == CLKS_PER_CYCLE / 2 && !aec)
        aec_cnt++;
      if (t_x == CYCLES_PER_LINE - 1 && t_phase == CLKS_PER_CYCLE - 1) begin
        check_data("aec low periods", bad_m ? 8'd40 : 8'd0, cpu_data_t'(aec_cnt));
        if (video_on && aec_cnt != 0)
          bad_seen++;
        aec_cnt = 0;
      end
      ba_prev  = ba;
      aec_prev = aec;

      if (video_on) begin
        if (bad_m && t_x >= FETCH_FIRST && t_x <= FETCH_LAST && t_phase >= 4)
          check_addr("matrix fetch", matrix_addr(row_m, t_x - FETCH_FIRST), ram_addr);
        if (win_m && t_x >= WIN_X_FIRST && t_x <= WIN_X_LAST && t_phase < 4)
          check_addr("char fetch", char_addr(row_m, t_x - WIN_X_FIRST, rc_m), ram_addr);
        // Pixels trail their character fetch by one bus cycle
        if (win_m && t_x > WIN_X_FIRST && t_x <= WIN_X_LAST + 1)
          check_color("window pixel",
                      pixel_expect(row_m, t_x - WIN_X_FIRST - 1, rc_m, t_phase), pixel_color);
        else
          check_color("border pixel", border_sh, pixel_color);
      end
    end
  end

  always @(posedge clk) begin
    clk_count <= clk_count + 1;
    if (clk_count >= TIMEOUT_CLKS) begin
      $display("Timeout: the run did not finish within %0d clk", TIMEOUT_CLKS);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    rst     = 1'b1;
    cs_n    = 1'b1;
    rw      = 1'b1;
    addr    = '0;
    data_in = '0;
    seed    = 73;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_bit("ba in reset", 1'b1, ba);
    check_bit("aec in reset", 1'b1, aec);
    check_bit("irq_n in reset", 1'b1, irq_n);
    check_bit("data_oe in reset", 1'b0, data_oe);
    check_bit("hsync in reset", 1'b0, hsync);
    @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    mon_on = 1'b1;

    for (int i = 0; i < N_REGS; i++) begin
      bus_write(tbl_addr[i], tbl_wr[i]);
      bus_read(tbl_addr[i], rd);
      check_data(tbl_name[i], tbl_exp[i], rd);
    end
    bus_read(REG_RASTER, rd);
    check_data("raster live read", cpu_data_t'(last_read_y), rd);

    // Raster interrupt on a random line
    irq_line = 60 + (($random(seed) & 32'h7FFF_FFFF) % 141);
    bus_write(REG_RASTER, cpu_data_t'(irq_line));
    bus_write(REG_IRQ_EN, 8'h01);
    do @(negedge clk); while (irq_n);
    check_data("irq line", cpu_data_t'(irq_line), cpu_data_t'(t_y));
    check_bit("irq one clk into line", 1'b1, t_x == 0 && t_phase == 1);
    bus_read(REG_IRQ, rd);
    check_data("irq status pending", 8'h81, rd);
    bus_write(REG_IRQ, 8'h01);
    @(negedge clk);
    check_bit("irq_n after clear", 1'b1, irq_n);
    bus_read(REG_IRQ, rd);
    check_data("irq status cleared", 8'h00, rd);

    // Same source with the enable off must leave irq_n high
    bus_write(REG_IRQ_EN, 8'h00);
    bus_write(REG_RASTER, cpu_data_t'(irq_line + 5));
    do begin
      @(negedge clk);
      check_bit("irq_n masked", 1'b1, irq_n);
    end while (t_y != irq_line + 6);
    bus_read(REG_IRQ, rd);
    check_data("irq status masked", 8'h01, rd);
    bus_write(REG_IRQ, 8'h01);

    // DEN goes on past the window, so DMA starts with the next frame
    wait_line(0, 260);
    bus_write(REG_CTRL1, 8'h13);
    wait_line(1, 0);
    video_on = 1'b1;
    wait_line(1, 260);
    video_on = 1'b0;
    check_data("bad lines in frame", 8'd25, cpu_data_t'(bad_seen));

    $display("Errors: data %0d, address %0d, colour %0d, bit %0d",
             err_data, err_addr, err_color, err_bit);
    if (err_data + err_addr + err_color + err_bit == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* files.f */
vic_pkg.sv
vic_raster_if.sv
vic_raster_timer.sv
vic_reg_file.sv
vic_dma_ctrl.sv
vic_pixel_gen.sv
vic_top.sv
vic_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= vic_top_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
